// ==== common/l2_pkg.sv ====
/*
 * Sizes, operation codes and the request address type of the L2 cache.
 * Lines are one 32-bit word with a byte mask. Ways and sets are powers of two.
 */
package l2_pkg;

	// Cores sharing the L2
	localparam int num_cores = 2;
	localparam int core_index_width = 1;

	// L2 geometry
	localparam int l2_num_ways = 4;
	localparam int l2_way_width = 2;
	localparam int l2_set_width = 4;
	localparam int l2_num_sets = 1 << l2_set_width;
	localparam int address_width = 26;
	localparam int l2_tag_width = address_width - l2_set_width;

	// L1 data cache geometry as seen by the directory
	localparam int l1_set_width = 3;
	localparam int l1_num_sets = 1 << l1_set_width;
	localparam int l1_tag_width = address_width - l1_set_width;
	localparam int l1_way_width = 2;
	localparam int l1_num_ways = 1 << l1_way_width;

	// One word per line, one mask bit per byte
	localparam int data_width = 32;
	localparam int mask_width = data_width / 8;

	// Request operations
	localparam logic [2:0] op_load = 3'd0;
	localparam logic [2:0] op_store = 3'd1;
	localparam logic [2:0] op_flush = 3'd2;
	localparam logic [2:0] op_dinvalidate = 3'd3;

	// Requesting units
	localparam logic [1:0] unit_icache = 2'd0;
	localparam logic [1:0] unit_dcache = 2'd1;

	typedef struct packed {
		logic [l2_tag_width-1:0] tag;
		logic [l2_set_width-1:0] set;
	} l2_view_t;

	typedef struct packed {
		logic [l1_tag_width-1:0] tag;
		logic [l1_set_width-1:0] set;
	} l1_view_t;

	// The same line address split for the L2 arrays and for the L1 directory
	typedef union packed {
		l2_view_t l2;
		l1_view_t l1;
	} l2_addr_t;

endpackage

// ==== common/l2_stage_if.sv ====
/*
 * Request plus lookup results or decisions between two pipeline stages.
 * The source stage drives every field, tying off the ones its hop does not use.
 */
`timescale 1ns/100ps

interface l2_stage_if;
	import l2_pkg::*;

	// Request fields
	logic valid;
	logic [core_index_width-1:0] core;
	logic [1:0] unit;
	logic [2:0] op;
	logic [l1_way_width-1:0] l1_way;
	l2_addr_t address;
	logic [data_width-1:0] data;
	logic [mask_width-1:0] mask;
	logic restarted;
	logic [data_width-1:0] mem_data;
	logic [l2_way_width-1:0] fill_way;

	// Lookup results, tag stage to directory stage
	logic [l2_num_ways-1:0][l2_tag_width-1:0] way_tag;
	logic [l2_num_ways-1:0] way_valid;
	logic [l2_num_ways-1:0] way_dirty;
	logic [num_cores-1:0] l1_has_line;
	logic [num_cores-1:0][l1_way_width-1:0] l1_line_way;

	// Decisions, directory stage to data stage
	logic cache_hit;
	logic [l2_way_width-1:0] hit_way;
	logic is_fill;
	logic [l2_tag_width-1:0] victim_tag;
	logic victim_dirty;
	logic l1_invalidate;

	modport src(output valid, core, unit, op, l1_way, address, data, mask, restarted,
		mem_data, fill_way, way_tag, way_valid, way_dirty, l1_has_line, l1_line_way,
		cache_hit, hit_way, is_fill, victim_tag, victim_dirty, l1_invalidate);

	modport dst(input valid, core, unit, op, l1_way, address, data, mask, restarted,
		mem_data, fill_way, way_tag, way_valid, way_dirty, l1_has_line, l1_line_way,
		cache_hit, hit_way, is_fill, victim_tag, victim_dirty, l1_invalidate);

endinterface

// ==== dv/l2_cache_tb.sv ====
/*
 * Testbench for the L2 cache pipeline. A line and directory model predicts every response.
 * The testbench plays memory and reissues missed loads and partial-mask stores as fills.
 */
`timescale 1ns/100ps

module l2_cache_tb;

	import l2_pkg::*;

	typedef struct packed {
		logic [core_index_width-1:0] core;
		logic [1:0] unit;
		logic [2:0] op;
		logic hit;
		logic fill;
		logic [data_width-1:0] data;
		logic l1_inv;
		logic wb;
		logic [address_width-1:0] wb_addr;
		logic [data_width-1:0] wb_data;
		logic hit_ev;
		logic miss_ev;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	logic [core_index_width-1:0] req_core;
	logic [1:0] req_unit;
	logic [2:0] req_op;
	logic [l1_way_width-1:0] req_l1_way;
	logic [address_width-1:0] req_address;
	logic [data_width-1:0] req_data;
	logic [mask_width-1:0] req_mask;
	logic req_restarted;
	logic [data_width-1:0] req_mem_data;
	logic [l2_way_width-1:0] req_fill_way;
	logic resp_valid;
	logic [core_index_width-1:0] resp_core;
	logic [1:0] resp_unit;
	logic [2:0] resp_op;
	logic resp_hit;
	logic resp_fill;
	logic [data_width-1:0] resp_data;
	logic resp_l1_invalidate;
	logic wb_valid;
	logic [address_width-1:0] wb_address;
	logic [data_width-1:0] wb_data;
	logic hit_event;
	logic miss_event;

	// Model of the L2 lines, of each core's L1 contents and of memory
	logic line_valid [l2_num_sets][l2_num_ways];
	logic line_dirty [l2_num_sets][l2_num_ways];
	logic [l2_tag_width-1:0] line_tag [l2_num_sets][l2_num_ways];
	logic [data_width-1:0] line_data [l2_num_sets][l2_num_ways];
	logic held_valid [num_cores][l1_num_sets][l1_num_ways];
	logic [l1_tag_width-1:0] held_tag [num_cores][l1_num_sets][l1_num_ways];
	logic [data_width-1:0] mem_words [logic [address_width-1:0]];

	expect_t expect_q [$];
	int issued;
	int responses_seen;

	l2_cache_top u_dut(
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_core(req_core), .req_unit(req_unit),
		.req_op(req_op), .req_l1_way(req_l1_way), .req_address(req_address),
		.req_data(req_data), .req_mask(req_mask), .req_restarted(req_restarted),
		.req_mem_data(req_mem_data), .req_fill_way(req_fill_way),
		.resp_valid(resp_valid), .resp_core(resp_core), .resp_unit(resp_unit),
		.resp_op(resp_op), .resp_hit(resp_hit), .resp_fill(resp_fill),
		.resp_data(resp_data), .resp_l1_invalidate(resp_l1_invalidate),
		.wb_valid(wb_valid), .wb_address(wb_address), .wb_data(wb_data),
		.hit_event(hit_event), .miss_event(miss_event));

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	task automatic fail_run(input string line);
		$display("STATUS: FAIL");
		$display("%s", line);
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want)
		else
			fail_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want));
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond)
		else
			fail_run($sformatf("Directed sequence did not behave as intended: %s", what));
	endtask

	function automatic logic [data_width-1:0] mem_read(input logic [address_width-1:0] addr);
		if (mem_words.exists(addr))
			return mem_words[addr];
		// Untouched memory holds a word derived from every address bit
		return {6'b0, addr} * 32'h9e37_79b9;
	endfunction

	// Finds the L1 way where a core holds the line
	function automatic void l1_lookup(input logic [core_index_width-1:0] core,
		input logic [address_width-1:0] addr, output logic has,
		output logic [l1_way_width-1:0] way);
		has = 1'b0;
		way = '0;
		for (int w = 0; w < l1_num_ways; w++)
		begin
			if (held_valid[core][addr[l1_set_width-1:0]][w]
				&& held_tag[core][addr[l1_set_width-1:0]][w] == addr[address_width-1:l1_set_width])
			begin
				has = 1'b1;
				way = l1_way_width'(w);
			end
		end
	endfunction

	// Applies one request to the model and returns what the DUT should answer
	function automatic expect_t model_request(input logic [core_index_width-1:0] core,
		input logic [1:0] unit, input logic [2:0] op, input logic [l1_way_width-1:0] l1_way,
		input logic [address_width-1:0] addr, input logic [data_width-1:0] data,
		input logic [mask_width-1:0] mask, input logic restarted,
		input logic [data_width-1:0] mem_data, input logic [l2_way_width-1:0] fill_way);
		expect_t e;
		logic [l2_set_width-1:0] set;
		logic [l2_tag_width-1:0] tag;
		logic [l2_way_width-1:0] way;
		logic [l1_way_width-1:0] held_way;
		logic has_line;
		logic [data_width-1:0] old_word;
		logic [data_width-1:0] word;
		set = addr[l2_set_width-1:0];
		tag = addr[address_width-1:l2_set_width];
		e = '0;
		e.core = core;
		e.unit = unit;
		e.op = op;
		way = '0;
		for (int w = 0; w < l2_num_ways; w++)
		begin
			if (line_valid[set][w] && line_tag[set][w] == tag)
			begin
				e.hit = 1'b1;
				way = l2_way_width'(w);
			end
		end
		// Restarts always fill, and so does a store that covers the whole line
		e.fill = restarted || (op == op_store && mask == '1 && !e.hit);
		if (e.fill)
			way = fill_way;
		l1_lookup(core, addr, has_line, held_way);
		e.l1_inv = op == op_dinvalidate && has_line;
		e.hit_ev = !restarted && (op == op_load || op == op_store) && e.hit;
		e.miss_ev = !restarted && (op == op_load || op == op_store) && !e.hit;
		old_word = line_data[set][way];
		word = e.fill ? mem_data : old_word;
		if (op == op_store)
			for (int b = 0; b < mask_width; b++)
				if (mask[b])
					word[b * 8 +: 8] = data[b * 8 +: 8];
		if (e.fill || e.hit)
			e.data = word;
		// A dirty victim or a flushed dirty line goes back to memory
		if (line_valid[set][way] && line_dirty[set][way] && (e.fill || (e.hit && op == op_flush)))
		begin
			e.wb = 1'b1;
			e.wb_addr = {line_tag[set][way], set};
			e.wb_data = old_word;
			mem_words[e.wb_addr] = old_word;
		end
		if (e.fill)
		begin
			line_valid[set][way] = 1'b1;
			line_tag[set][way] = tag;
			line_data[set][way] = word;
			line_dirty[set][way] = op == op_store;
		end
		else if (e.hit && op == op_store)
		begin
			line_data[set][way] = word;
			line_dirty[set][way] = 1'b1;
		end
		else if (e.hit && op == op_flush)
			line_dirty[set][way] = 1'b0;
		else if (e.hit && op == op_dinvalidate)
			line_valid[set][way] = 1'b0;
		// Only data-cache loads put a line into an L1
		if (op == op_load && unit == unit_dcache && (e.hit || e.fill))
		begin
			held_valid[core][addr[l1_set_width-1:0]][l1_way] = 1'b1;
			held_tag[core][addr[l1_set_width-1:0]][l1_way] = addr[address_width-1:l1_set_width];
		end
		else if (e.l1_inv)
			held_valid[core][addr[l1_set_width-1:0]][held_way] = 1'b0;
		return e;
	endfunction

	task automatic wait_responses();
		int cycles;
		cycles = 0;
		while (responses_seen != issued)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 20)
				fail_run($sformatf("Timed out waiting for %0d outstanding responses",
					issued - responses_seen));
		end
	endtask

	// Drives one request for a single cycle starting at a falling edge
	task automatic issue(input logic [core_index_width-1:0] core, input logic [1:0] unit,
		input logic [2:0] op, input logic [l1_way_width-1:0] l1_way,
		input logic [address_width-1:0] addr, input logic [data_width-1:0] data,
		input logic [mask_width-1:0] mask, input logic restarted,
		input logic [data_width-1:0] mem_data, input logic [l2_way_width-1:0] fill_way,
		output expect_t e);
		req_valid = 1'b1;
		req_core = core;
		req_unit = unit;
		req_op = op;
		req_l1_way = l1_way;
		req_address = addr;
		req_data = data;
		req_mask = mask;
		req_restarted = restarted;
		req_mem_data = mem_data;
		req_fill_way = fill_way;
		e = model_request(core, unit, op, l1_way, addr, data, mask, restarted, mem_data, fill_way);
		expect_q.push_back(e);
		issued++;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	// Issues one access and on a miss plays memory by reissuing it with memory data
	task automatic access(input logic [core_index_width-1:0] core, input logic [1:0] unit,
		input logic [2:0] op, input logic [address_width-1:0] addr,
		input logic [data_width-1:0] data, input logic [mask_width-1:0] mask,
		input logic [l2_way_width-1:0] fill_way, output expect_t first, output expect_t last);
		logic has;
		logic [l1_way_width-1:0] l1_way;
		// A line already in the L1 keeps its way
		l1_lookup(core, addr, has, l1_way);
		if (!has)
			l1_way = l1_way_width'($urandom_range(0, l1_num_ways - 1));
		issue(core, unit, op, l1_way, addr, data, mask, 1'b0, '0, fill_way, first);
		last = first;
		if (!first.hit && !first.fill && (op == op_load || op == op_store))
		begin
			wait_responses();
			issue(core, unit, op, l1_way, addr, data, mask, 1'b1, mem_read(addr), fill_way, last);
		end
	endtask

	task automatic random_access();
		expect_t first;
		expect_t last;
		logic [2:0] op;
		logic [1:0] unit;
		logic [mask_width-1:0] mask;
		logic [address_width-1:0] addr;
		int pick;
		pick = $urandom_range(0, 9);
		if (pick < 4)
			op = op_load;
		else if (pick < 7)
			op = op_store;
		else if (pick < 9)
			op = op_flush;
		else
			op = op_dinvalidate;
		unit = ($urandom_range(0, 3) == 0) ? unit_icache : unit_dcache;
		mask = ($urandom_range(0, 2) == 0) ? '1 : mask_width'($urandom);
		// Six tags over four sets keep the ways under pressure
		addr = {l2_tag_width'(22'h100 + $urandom_range(0, 5)), l2_set_width'($urandom_range(0, 3))};
		access(core_index_width'($urandom), unit, op, addr, $urandom, mask,
			l2_way_width'($urandom), first, last);
	endtask

	// Compares each response with the oldest expected item
	// Events lead the response by two cycles, so they pass through a two-stage delay
	initial
	begin
		expect_t e;
		logic hit_d1;
		logic hit_d2;
		logic miss_d1;
		logic miss_d2;
		hit_d1 = 1'b0;
		hit_d2 = 1'b0;
		miss_d1 = 1'b0;
		miss_d2 = 1'b0;
		forever
		begin
			@(negedge clk);
			if (resp_valid)
			begin
				assert (expect_q.size() > 0)
				else
					fail_run("The DUT gave a response that no request was waiting for");
				e = expect_q.pop_front();
				check_field("resp_core", resp_core, e.core);
				check_field("resp_unit", resp_unit, e.unit);
				check_field("resp_op", resp_op, e.op);
				check_field("resp_hit", resp_hit, e.hit);
				check_field("resp_fill", resp_fill, e.fill);
				check_field("resp_data", resp_data, e.data);
				check_field("resp_l1_invalidate", resp_l1_invalidate, e.l1_inv);
				check_field("wb_valid", wb_valid, e.wb);
				if (e.wb)
				begin
					check_field("wb_address", wb_address, e.wb_addr);
					check_field("wb_data", wb_data, e.wb_data);
				end
				check_field("hit_event", hit_d2, e.hit_ev);
				check_field("miss_event", miss_d2, e.miss_ev);
				responses_seen <= responses_seen + 1;
			end
			else
			begin
				assert (!wb_valid && !hit_d2 && !miss_d2)
				else
					fail_run("The DUT raised a write-back or an event without a response");
			end
			hit_d2 = hit_d1;
			hit_d1 = hit_event;
			miss_d2 = miss_d1;
			miss_d1 = miss_event;
		end
	end

	initial
	begin
		expect_t first;
		expect_t last;
		logic [address_width-1:0] a1;
		logic [address_width-1:0] a2;
		logic [address_width-1:0] a3;
		logic [address_width-1:0] a4;
		logic [address_width-1:0] a5;
		logic [data_width-1:0] merged;
		void'($urandom(48));
		reset = 1'b1;
		req_valid = 1'b0;
		req_core = '0;
		req_unit = unit_dcache;
		req_op = op_load;
		req_l1_way = '0;
		req_address = '0;
		req_data = '0;
		req_mask = '0;
		req_restarted = 1'b0;
		req_mem_data = '0;
		req_fill_way = '0;
		issued = 0;
		for (int s = 0; s < l2_num_sets; s++)
			for (int w = 0; w < l2_num_ways; w++)
			begin
				line_valid[s][w] = 1'b0;
				line_dirty[s][w] = 1'b0;
				line_tag[s][w] = '0;
				line_data[s][w] = '0;
			end
		for (int c = 0; c < num_cores; c++)
			for (int s = 0; s < l1_num_sets; s++)
				for (int w = 0; w < l1_num_ways; w++)
				begin
					held_valid[c][s][w] = 1'b0;
					held_tag[c][s][w] = '0;
				end
		a1 = {22'h000040, 4'h1};
		a3 = {22'h000041, 4'h1};
		a2 = {22'h000050, 4'h2};
		a4 = {22'h000060, 4'h5};
		a5 = {22'h000070, 4'h6};
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Cold miss, fill from memory, then a hit on the same line
		access(1'b0, unit_dcache, op_load, a1, '0, '0, 2'd0, first, last);
		expect_true(first.miss_ev && !first.wb, "first load after reset misses");
		expect_true(last.fill && last.data == mem_read(a1), "restart fills with memory data");
		access(1'b0, unit_dcache, op_load, a1, '0, '0, 2'd0, first, last);
		expect_true(first.hit && first.hit_ev && first.data == mem_read(a1), "repeat load hits");

		// Partial store merges bytes 0 and 2
		merged = mem_read(a1);
		merged = {merged[31:24], 8'h22, merged[15:8], 8'h44};
		access(1'b0, unit_dcache, op_store, a1, 32'h1122_3344, 4'b0101, 2'd0, first, last);
		access(1'b0, unit_dcache, op_load, a1, '0, '0, 2'd0, first, last);
		expect_true(first.hit && first.data == merged, "load after store sees merged bytes");
		access(1'b1, unit_dcache, op_store, a2, 32'hcafe_f00d, 4'hf, 2'd3, first, last);
		expect_true(first.fill && first.miss_ev && first.data == 32'hcafe_f00d,
			"full-mask store miss fills at once");

		// Dirty victim on a fill, then flushes of a dirty line
		access(1'b0, unit_dcache, op_load, a3, '0, '0, 2'd0, first, last);
		expect_true(last.wb && last.wb_addr == a1 && last.wb_data == merged,
			"fill over a dirty line writes the victim back");
		access(1'b1, unit_icache, op_flush, a2, '0, '0, 2'd0, first, last);
		expect_true(first.hit && first.wb && first.wb_data == 32'hcafe_f00d, "flush writes back");
		access(1'b1, unit_icache, op_flush, a2, '0, '0, 2'd0, first, last);
		expect_true(first.hit && !first.wb, "second flush finds the line clean");

		// L1 directory tracking and data invalidation
		access(1'b1, unit_dcache, op_load, a4, '0, '0, 2'd1, first, last);
		access(1'b1, unit_dcache, op_dinvalidate, a4, '0, '0, 2'd1, first, last);
		expect_true(first.hit && first.l1_inv, "invalidate finds the line in the L1");
		access(1'b1, unit_dcache, op_load, a4, '0, '0, 2'd1, first, last);
		expect_true(first.miss_ev, "load after invalidate misses");
		access(1'b0, unit_icache, op_load, a5, '0, '0, 2'd2, first, last);
		access(1'b0, unit_dcache, op_dinvalidate, a5, '0, '0, 2'd2, first, last);
		expect_true(first.hit && !first.l1_inv, "instruction fetch leaves no L1 record");

		for (int i = 0; i < 600; i++)
			random_access();
		wait_responses();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== l2_cache/l2_cache_data.sv ====
/*
 * Last stage. Holds line data, merges stores and registers the response.
 * A dirty victim or a flushed dirty line leaves as a one-cycle write-back.
 */
`timescale 1ns/100ps

module l2_cache_data(
	input clk,
	input reset,
	l2_stage_if.dst in,
	output logic resp_valid,
	output logic [l2_pkg::core_index_width-1:0] resp_core,
	output logic [1:0] resp_unit,
	output logic [2:0] resp_op,
	output logic resp_hit,
	output logic resp_fill,
	output logic [l2_pkg::data_width-1:0] resp_data,
	output logic resp_l1_invalidate,
	output logic wb_valid,
	output logic [l2_pkg::address_width-1:0] wb_address,
	output logic [l2_pkg::data_width-1:0] wb_data);

	import l2_pkg::*;

	logic [data_width-1:0] data_array [l2_num_sets][l2_num_ways];
	logic [l2_way_width-1:0] way;
	logic [data_width-1:0] old_line;
	logic [data_width-1:0] base_line;
	logic [data_width-1:0] new_line;

	wire is_store = in.op == op_store;
	wire line_write = in.valid && (in.is_fill || (in.cache_hit && is_store));

	// Victim data and hit data come from the same read port
	assign way = in.is_fill ? in.fill_way : in.hit_way;
	assign old_line = data_array[in.address.l2.set][way];
	assign base_line = in.is_fill ? in.mem_data : old_line;

	// Byte merge of store data. A full mask replaces the memory word entirely
	always_comb
	begin
		new_line = base_line;
		if (is_store)
			for (int b = 0; b < mask_width; b++)
				if (in.mask[b])
					new_line[b * 8 +: 8] = in.data[b * 8 +: 8];
	end

	always_ff @(posedge clk)
	begin
		if (line_write)
			data_array[in.address.l2.set][way] <= new_line;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			wb_valid <= 1'b0;
		end
		else
		begin
			resp_valid <= in.valid;
			// Victim tag and dirty follow the hit way when this is not a fill
			wb_valid <= in.valid && in.victim_dirty
				&& (in.is_fill || (in.cache_hit && in.op == op_flush));
		end
	end

	always_ff @(posedge clk)
	begin
		resp_core <= in.core;
		resp_unit <= in.unit;
		resp_op <= in.op;
		resp_hit <= in.cache_hit;
		resp_fill <= in.is_fill;
		resp_data <= (in.is_fill || in.cache_hit) ? new_line : '0;
		resp_l1_invalidate <= in.l1_invalidate;
		wb_address <= {in.victim_tag, in.address.l2.set};
		wb_data <= old_line;
	end

endmodule

// ==== l2_cache/l2_cache_dir.sv ====
/*
 * Second stage. Decides hit, fill and victim, and sends array updates back.
 * Updates are combinational and written by the tag stage on this stage's edge.
 */
`timescale 1ns/100ps

module l2_cache_dir(
	input clk,
	input reset,
	l2_stage_if.dst in,
	l2_stage_if.src out,
	output logic tag_upd_enable,
	output logic [l2_pkg::l2_set_width-1:0] tag_upd_set,
	output logic [l2_pkg::l2_way_width-1:0] tag_upd_way,
	output logic [l2_pkg::l2_tag_width-1:0] tag_upd_tag,
	output logic tag_upd_valid,
	output logic [l2_pkg::l2_num_ways-1:0] dirty_upd_enable,
	output logic [l2_pkg::l2_set_width-1:0] dirty_upd_set,
	output logic dirty_upd_value,
	output logic dir_upd_enable,
	output logic [l2_pkg::core_index_width-1:0] dir_upd_core,
	output logic [l2_pkg::l1_set_width-1:0] dir_upd_set,
	output logic [l2_pkg::l1_way_width-1:0] dir_upd_way,
	output logic [l2_pkg::l1_tag_width-1:0] dir_upd_tag,
	output logic dir_upd_valid,
	output logic hit_event,
	output logic miss_event);

	import l2_pkg::*;

	logic [l2_num_ways-1:0] hit_vec;
	logic [l2_way_width-1:0] hit_way;
	logic cache_hit;
	logic is_fill;
	logic [l2_way_width-1:0] victim_way;
	logic update_dirty;

	wire is_load = in.op == op_load;
	wire is_store = in.op == op_store;
	wire is_flush = in.op == op_flush;
	wire invalidate = in.op == op_dinvalidate;

	// Tag compare per way, at most one way can match
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < l2_num_ways; w++)
		begin
			hit_vec[w] = in.way_valid[w] && in.way_tag[w] == in.address.l2.tag;
			if (hit_vec[w])
				hit_way = l2_way_width'(w);
		end
	end

	assign cache_hit = |hit_vec;

	// A store covering the whole line needs no memory data, so it fills right away
	assign is_fill = in.restarted || (is_store && in.mask == '1 && !cache_hit);
	assign victim_way = is_fill ? in.fill_way : hit_way;

	// Install the tag on a fill, or drop the line on an invalidate hit
	assign tag_upd_enable = in.valid && (is_fill || (invalidate && cache_hit));
	assign tag_upd_set = in.address.l2.set;
	assign tag_upd_way = invalidate ? hit_way : in.fill_way;
	assign tag_upd_tag = in.address.l2.tag;
	assign tag_upd_valid = !invalidate;

	assign update_dirty = in.valid && (is_fill || (cache_hit && (is_store || is_flush)));
	assign dirty_upd_set = in.address.l2.set;

	always_comb
	begin
		for (int w = 0; w < l2_num_ways; w++)
			dirty_upd_enable[w] = update_dirty && (is_fill ? in.fill_way == w : hit_vec[w]);
		if (is_fill)
			dirty_upd_value = is_store; // Fresh line is dirty only if a store lands on it
		else if (is_flush)
			dirty_upd_value = 1'b0;
		else
			dirty_upd_value = 1'b1;
	end

	// Track lines pushed to an L1 data cache, and forget them on invalidate.
	// Stores do not allocate in the L1, so only loads are recorded
	assign dir_upd_enable = in.valid
		&& ((is_load && in.unit == unit_dcache && (cache_hit || is_fill))
		|| (invalidate && in.l1_has_line[in.core]));
	assign dir_upd_core = in.core;
	assign dir_upd_set = in.address.l1.set;
	assign dir_upd_way = invalidate ? in.l1_line_way[in.core] : in.l1_way;
	assign dir_upd_tag = in.address.l1.tag;
	assign dir_upd_valid = !invalidate;

	// Count only the first pass of loads and stores
	always_comb
	begin
		hit_event = 1'b0;
		miss_event = 1'b0;
		if (in.valid && !in.restarted && (is_load || is_store))
		begin
			if (cache_hit)
				hit_event = 1'b1;
			else
				miss_event = 1'b1;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		out.core <= in.core;
		out.unit <= in.unit;
		out.op <= in.op;
		out.l1_way <= in.l1_way;
		out.address <= in.address;
		out.data <= in.data;
		out.mask <= in.mask;
		out.restarted <= in.restarted;
		out.mem_data <= in.mem_data;
		out.fill_way <= in.fill_way;
		out.cache_hit <= cache_hit;
		out.hit_way <= hit_way;
		out.is_fill <= is_fill;
		out.victim_tag <= in.way_tag[victim_way];
		out.victim_dirty <= in.way_valid[victim_way] && in.way_dirty[victim_way];
		out.l1_invalidate <= invalidate && in.l1_has_line[in.core];
	end

	// The data stage has no use for raw lookup results
	assign out.way_tag = '0;
	assign out.way_valid = '0;
	assign out.way_dirty = '0;
	assign out.l1_has_line = '0;
	assign out.l1_line_way = '0;

endmodule

// ==== l2_cache/l2_cache_tag.sv ====
/*
 * First stage. Registers the request and looks up tags and the L1 directory.
 * Array updates from the directory stage land at the edge that loads the next request.
 */
`timescale 1ns/100ps

module l2_cache_tag(
	input clk,
	input reset,
	input req_valid,
	input [l2_pkg::core_index_width-1:0] req_core,
	input [1:0] req_unit,
	input [2:0] req_op,
	input [l2_pkg::l1_way_width-1:0] req_l1_way,
	input l2_pkg::l2_addr_t req_address,
	input [l2_pkg::data_width-1:0] req_data,
	input [l2_pkg::mask_width-1:0] req_mask,
	input req_restarted,
	input [l2_pkg::data_width-1:0] req_mem_data,
	input [l2_pkg::l2_way_width-1:0] req_fill_way,
	input tag_upd_enable,
	input [l2_pkg::l2_set_width-1:0] tag_upd_set,
	input [l2_pkg::l2_way_width-1:0] tag_upd_way,
	input [l2_pkg::l2_tag_width-1:0] tag_upd_tag,
	input tag_upd_valid,
	input [l2_pkg::l2_num_ways-1:0] dirty_upd_enable,
	input [l2_pkg::l2_set_width-1:0] dirty_upd_set,
	input dirty_upd_value,
	input dir_upd_enable,
	input [l2_pkg::core_index_width-1:0] dir_upd_core,
	input [l2_pkg::l1_set_width-1:0] dir_upd_set,
	input [l2_pkg::l1_way_width-1:0] dir_upd_way,
	input [l2_pkg::l1_tag_width-1:0] dir_upd_tag,
	input dir_upd_valid,
	l2_stage_if.src out);

	import l2_pkg::*;

	// L2 tag state, one entry per set and way
	logic [l2_tag_width-1:0] tag_array [l2_num_sets][l2_num_ways];
	logic [l2_num_ways-1:0] valid_array [l2_num_sets];
	logic [l2_num_ways-1:0] dirty_array [l2_num_sets];

	// Shadow of each core's L1 data cache tags
	logic [l1_tag_width-1:0] dir_tag [num_cores][l1_num_sets][l1_num_ways];
	logic [l1_num_ways-1:0] dir_valid [num_cores][l1_num_sets];

	// Request register
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		out.core <= req_core;
		out.unit <= req_unit;
		out.op <= req_op;
		out.l1_way <= req_l1_way;
		out.address <= req_address;
		out.data <= req_data;
		out.mask <= req_mask;
		out.restarted <= req_restarted;
		out.mem_data <= req_mem_data;
		out.fill_way <= req_fill_way;
	end

	// Valid, dirty and L1 directory bits written from the update buses
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < l2_num_sets; s++)
			begin
				valid_array[s] <= '0;
				dirty_array[s] <= '0;
			end
			for (int c = 0; c < num_cores; c++)
				for (int s = 0; s < l1_num_sets; s++)
					dir_valid[c][s] <= '0;
		end
		else
		begin
			if (tag_upd_enable)
				valid_array[tag_upd_set][tag_upd_way] <= tag_upd_valid;
			for (int w = 0; w < l2_num_ways; w++)
				if (dirty_upd_enable[w])
					dirty_array[dirty_upd_set][w] <= dirty_upd_value;
			if (dir_upd_enable)
				dir_valid[dir_upd_core][dir_upd_set][dir_upd_way] <= dir_upd_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tag_upd_enable)
			tag_array[tag_upd_set][tag_upd_way] <= tag_upd_tag;
		if (dir_upd_enable)
			dir_tag[dir_upd_core][dir_upd_set][dir_upd_way] <= dir_upd_tag;
	end

	// Read every way of the L2 set, then search each core's L1 set for the line
	always_comb
	begin
		for (int w = 0; w < l2_num_ways; w++)
			out.way_tag[w] = tag_array[out.address.l2.set][w];
		out.way_valid = valid_array[out.address.l2.set];
		out.way_dirty = dirty_array[out.address.l2.set];
		for (int c = 0; c < num_cores; c++)
		begin
			out.l1_has_line[c] = 1'b0;
			out.l1_line_way[c] = '0;
			for (int w = 0; w < l1_num_ways; w++)
			begin
				if (dir_valid[c][out.address.l1.set][w]
					&& dir_tag[c][out.address.l1.set][w] == out.address.l1.tag)
				begin
					out.l1_has_line[c] = 1'b1;
					out.l1_line_way[c] = l1_way_width'(w);
				end
			end
		end
	end

	// Decisions belong to the next hop
	assign out.cache_hit = 1'b0;
	assign out.hit_way = '0;
	assign out.is_fill = 1'b0;
	assign out.victim_tag = '0;
	assign out.victim_dirty = 1'b0;
	assign out.l1_invalidate = 1'b0;

endmodule

// ==== list.f ====
common/l2_pkg.sv
common/l2_stage_if.sv
l2_cache/l2_cache_tag.sv
l2_cache/l2_cache_dir.sv
l2_cache/l2_cache_data.sv
rtl/l2_cache_top.sv
dv/l2_cache_tb.sv

// ==== rtl/l2_cache_top.sv ====
/*
 * L2 cache pipeline with plain request, response and write-back ports.
 * One request per cycle at most, response two edges after the edge that samples the request.
 */
`timescale 1ns/100ps

module l2_cache_top(
	input clk,
	input reset,
	input req_valid,
	input [l2_pkg::core_index_width-1:0] req_core,
	input [1:0] req_unit,
	input [2:0] req_op,
	input [l2_pkg::l1_way_width-1:0] req_l1_way,
	input [l2_pkg::address_width-1:0] req_address,
	input [l2_pkg::data_width-1:0] req_data,
	input [l2_pkg::mask_width-1:0] req_mask,
	input req_restarted,
	input [l2_pkg::data_width-1:0] req_mem_data,
	input [l2_pkg::l2_way_width-1:0] req_fill_way,
	output logic resp_valid,
	output logic [l2_pkg::core_index_width-1:0] resp_core,
	output logic [1:0] resp_unit,
	output logic [2:0] resp_op,
	output logic resp_hit,
	output logic resp_fill,
	output logic [l2_pkg::data_width-1:0] resp_data,
	output logic resp_l1_invalidate,
	output logic wb_valid,
	output logic [l2_pkg::address_width-1:0] wb_address,
	output logic [l2_pkg::data_width-1:0] wb_data,
	output logic hit_event,
	output logic miss_event);

	import l2_pkg::*;

	// Update buses from the directory stage back to the tag arrays
	logic tag_upd_enable;
	logic [l2_set_width-1:0] tag_upd_set;
	logic [l2_way_width-1:0] tag_upd_way;
	logic [l2_tag_width-1:0] tag_upd_tag;
	logic tag_upd_valid;
	logic [l2_num_ways-1:0] dirty_upd_enable;
	logic [l2_set_width-1:0] dirty_upd_set;
	logic dirty_upd_value;
	logic dir_upd_enable;
	logic [core_index_width-1:0] dir_upd_core;
	logic [l1_set_width-1:0] dir_upd_set;
	logic [l1_way_width-1:0] dir_upd_way;
	logic [l1_tag_width-1:0] dir_upd_tag;
	logic dir_upd_valid;

	l2_stage_if tag_to_dir();
	l2_stage_if dir_to_data();

	l2_cache_tag u_tag(
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_core(req_core), .req_unit(req_unit),
		.req_op(req_op), .req_l1_way(req_l1_way), .req_address(req_address),
		.req_data(req_data), .req_mask(req_mask), .req_restarted(req_restarted),
		.req_mem_data(req_mem_data), .req_fill_way(req_fill_way),
		.tag_upd_enable(tag_upd_enable), .tag_upd_set(tag_upd_set),
		.tag_upd_way(tag_upd_way), .tag_upd_tag(tag_upd_tag), .tag_upd_valid(tag_upd_valid),
		.dirty_upd_enable(dirty_upd_enable), .dirty_upd_set(dirty_upd_set),
		.dirty_upd_value(dirty_upd_value),
		.dir_upd_enable(dir_upd_enable), .dir_upd_core(dir_upd_core),
		.dir_upd_set(dir_upd_set), .dir_upd_way(dir_upd_way),
		.dir_upd_tag(dir_upd_tag), .dir_upd_valid(dir_upd_valid),
		.out(tag_to_dir));

	l2_cache_dir u_dir(
		.clk(clk), .reset(reset),
		.in(tag_to_dir), .out(dir_to_data),
		.tag_upd_enable(tag_upd_enable), .tag_upd_set(tag_upd_set),
		.tag_upd_way(tag_upd_way), .tag_upd_tag(tag_upd_tag), .tag_upd_valid(tag_upd_valid),
		.dirty_upd_enable(dirty_upd_enable), .dirty_upd_set(dirty_upd_set),
		.dirty_upd_value(dirty_upd_value),
		.dir_upd_enable(dir_upd_enable), .dir_upd_core(dir_upd_core),
		.dir_upd_set(dir_upd_set), .dir_upd_way(dir_upd_way),
		.dir_upd_tag(dir_upd_tag), .dir_upd_valid(dir_upd_valid),
		.hit_event(hit_event), .miss_event(miss_event));

	l2_cache_data u_data(
		.clk(clk), .reset(reset),
		.in(dir_to_data),
		.resp_valid(resp_valid), .resp_core(resp_core), .resp_unit(resp_unit),
		.resp_op(resp_op), .resp_hit(resp_hit), .resp_fill(resp_fill),
		.resp_data(resp_data), .resp_l1_invalidate(resp_l1_invalidate),
		.wb_valid(wb_valid), .wb_address(wb_address), .wb_data(wb_data));

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the L2 cache testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module l2_cache_tb -f list.f -o l2_cache_sim
./obj_dir/l2_cache_sim | tee /dev/stderr | grep -qx "STATUS: PASS"
